/* src/aes_key_pkg.sv */
// key schedule widths, round count, window geometry, round key struct and rcon_word
`default_nettype none

package aes_key_pkg;

	parameter int key_len   = 128;                      // aes-128 cipher key
	parameter int no_rounds = 10;                       // round keys after the cipher key
	parameter int slice_w   = 80;                       // output window width

	// windows needed to cover the whole round key bank
	parameter int no_slices = (key_len * no_rounds + slice_w - 1) / slice_w;

	typedef logic [$clog2(no_slices)-1:0] slice_sel_t;  // window index

	typedef struct packed {
		logic [31:0] w0;                                // most significant word
		logic [31:0] w1;
		logic [31:0] w2;
		logic [31:0] w3;                                // feeds rotword of next round
	} round_key_t;

	// round constant with its byte in the top of the word
	function automatic logic [31:0] rcon_word(input int unsigned round_idx);
		logic [7:0] rc;
		case (round_idx)
			1:       rc = 8'h01;
			2:       rc = 8'h02;
			3:       rc = 8'h04;
			4:       rc = 8'h08;
			5:       rc = 8'h10;
			6:       rc = 8'h20;
			7:       rc = 8'h40;
			8:       rc = 8'h80;
			9:       rc = 8'h1b;                        // reduced by the aes polynomial
			10:      rc = 8'h36;
			default: rc = 8'h00;
		endcase
		return {rc, 24'h000000};
	endfunction

endpackage

`default_nettype wire

/* src/key_sbox.sv */
// aes forward s-box byte lookup
`timescale 1ns/100ps
`default_nettype none

module key_sbox (
	input  wire logic [7:0] in_byte,                    // byte to substitute
	output logic      [7:0] out_byte                    // substituted byte
);

	// forward s-box with row n holding entries 16n to 16n+15 and entry 0 leftmost
	localparam logic [0:255][7:0] sbox_tbl = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	// pure lookup without a clock
	always_comb begin
		out_byte = sbox_tbl[in_byte];
	end

endmodule

`default_nettype wire

/* src/round_key_gen.sv */
// one registered aes-128 key expansion stage with its valid bit
`timescale 1ns/100ps
`default_nettype none

module round_key_gen #(
	parameter int round_num = 1                         // 1 to 10, picks rcon
) (
	input  wire logic                    clk,
	input  wire logic                    rst_n,         // sync, active low
	input  wire logic                    prev_valid,    // previous round key valid
	input  wire aes_key_pkg::round_key_t prev_key,      // previous round key
	output aes_key_pkg::round_key_t      key,           // held round key
	output logic                         valid          // one cycle after load
);

	import aes_key_pkg::*;

	logic [31:0] rot_word;                              // rotword of prev w3
	logic [31:0] sub_word;                              // subword of rot_word
	logic [31:0] temp_word;                             // after rcon
	round_key_t  next_key;

	// rotate left by one byte
	assign rot_word = {prev_key.w3[23:0], prev_key.w3[31:24]};

	// subword, one s-box per byte
	for (genvar i = 0; i < 4; i++) begin : g_sub
		key_sbox u_sbox (
			.in_byte  (rot_word[8*i +: 8]),
			.out_byte (sub_word[8*i +: 8])
		);
	end

	assign temp_word = sub_word ^ rcon_word(round_num);

	// running xor across the four words
	always_comb begin
		next_key.w0 = prev_key.w0 ^ temp_word;
		next_key.w1 = prev_key.w1 ^ next_key.w0;
		next_key.w2 = prev_key.w2 ^ next_key.w1;
		next_key.w3 = prev_key.w3 ^ next_key.w2;
	end

	// load on valid input, hold otherwise
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			key   <= '0;
			valid <= 1'b0;
		end else begin
			valid <= prev_valid;                        // single cycle pulse follows input
			if (prev_valid) begin
				key <= next_key;
			end
		end
	end

endmodule

`default_nettype wire

/* src/key_expansion.sv */
// round stage chain, round key bank and output window selector
`timescale 1ns/100ps
`default_nettype none

module key_expansion #(
	parameter int key_len   = aes_key_pkg::key_len,     // cipher key width
	parameter int no_rounds = aes_key_pkg::no_rounds    // stages in the chain
) (
	input  wire logic                       clk,
	input  wire logic                       rst_n,      // sync, active low
	input  wire logic                       valid_in,   // one cycle per key
	input  wire aes_key_pkg::round_key_t    cipher_key,
	input  wire aes_key_pkg::slice_sel_t    slice_sel,  // window index
	output logic [aes_key_pkg::slice_w-1:0] key_slice,  // selected window of the bank
	output logic [no_rounds-1:0]            valid_out   // bit r-1 for round r
);

	import aes_key_pkg::*;

	localparam int bank_w     = key_len * no_rounds;                // all held round keys
	localparam int n_win      = (bank_w + slice_w - 1) / slice_w;   // windows over the bank
	localparam int bank_pad_w = n_win * slice_w;                    // bank rounded up to windows

	round_key_t             stage_key   [0:no_rounds];  // entry 0 is the cipher key
	logic [no_rounds:0]     stage_valid;
	logic [bank_w-1:0]      bank;
	logic [bank_pad_w-1:0]  bank_pad;

	assign stage_key[0]   = cipher_key;
	assign stage_valid[0] = valid_in;

	// each stage feeds the next
	for (genvar r = 1; r <= no_rounds; r++) begin : g_round
		round_key_gen #(
			.round_num (r)
		) u_round (
			.clk        (clk),
			.rst_n      (rst_n),
			.prev_valid (stage_valid[r-1]),
			.prev_key   (stage_key[r-1]),
			.key        (stage_key[r]),
			.valid      (stage_valid[r])
		);

		// round r sits at bits 128(r-1) up
		assign bank[key_len*(r-1) +: key_len] = stage_key[r];
	end

	assign valid_out = stage_valid[no_rounds:1];

	// top window zero filled when the bank is short
	assign bank_pad = bank_pad_w'(bank);

	// window mux straight from sel
	always_comb begin
		key_slice = '0;
		if (int'(slice_sel) < n_win) begin
			key_slice = bank_pad[slice_sel*slice_w +: slice_w];
		end
	end

endmodule

`default_nettype wire

/* src/aes_key_wrapper.sv */
// pin-limited top level around the key expansion
`timescale 1ns/100ps
`default_nettype none

module aes_key_wrapper #(
	parameter int key_len   = aes_key_pkg::key_len,     // fixed at 128
	parameter int no_rounds = aes_key_pkg::no_rounds    // may shrink for short schedules
) (
	input  wire logic                       clk,        // system clock
	input  wire logic                       rst_n,      // sync, active low
	input  wire logic                       valid_in,   // key strobe, no ack
	input  wire aes_key_pkg::round_key_t    cipher_key,
	input  wire aes_key_pkg::slice_sel_t    slice_sel,  // picks one 80-bit window
	output logic [aes_key_pkg::slice_w-1:0] key_slice,
	output logic [no_rounds-1:0]            valid_out   // one bit per round
);

	// whole schedule behind an 80-bit window
	key_expansion #(
		.key_len   (key_len),
		.no_rounds (no_rounds)
	) u_key_expansion (
		.clk        (clk),
		.rst_n      (rst_n),
		.valid_in   (valid_in),
		.cipher_key (cipher_key),
		.slice_sel  (slice_sel),
		.key_slice  (key_slice),
		.valid_out  (valid_out)
	);

endmodule

`default_nettype wire

/* verif/aes_key_wrapper_sva.sv */
// concurrent checks on the valid pipeline and reset and their bind to the top level
`timescale 1ns/100ps
`default_nettype none

module aes_key_wrapper_sva #(
	parameter int no_rounds = aes_key_pkg::no_rounds
) (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 valid_in,
	input  wire logic [no_rounds-1:0] valid_out
);

	// sync reset empties the pipeline
	reset_clears_valid: assert property (@(posedge clk) !rst_n |=> valid_out == '0)
		else $error("valid_out not all low one cycle after reset");

	stage1_follows_input: assert property (@(posedge clk) disable iff (!rst_n)
		valid_out[0] |-> $past(valid_in))
		else $error("valid_out[0] high without valid_in one cycle earlier");

	// each stage one cycle behind the one before
	for (genvar i = 1; i < no_rounds; i++) begin : g_chain
		stage_follows_prev: assert property (@(posedge clk) disable iff (!rst_n)
			valid_out[i] |-> $past(valid_out[i-1]))
			else $error("valid_out[%0d] high without valid_out[%0d] one cycle earlier",
				i, i - 1);
	end

endmodule

bind aes_key_wrapper aes_key_wrapper_sva #(
	.no_rounds (no_rounds)
) u_sva (
	.clk       (clk),
	.rst_n     (rst_n),
	.valid_in  (valid_in),
	.valid_out (valid_out)
);

`default_nettype wire

/* verif/tb_aes_key_wrapper.sv */
// testbench with clock, reset, pattern-driven stimulus, checks, watchdog and result
`timescale 1ns/100ps
`default_nettype none

module tb_aes_key_wrapper;

	import aes_key_pkg::*;

	localparam int n_vec       = 3;                     // a.1 key, all zero, all ones
	localparam int vec_words   = 11;                    // cipher key then round keys 1 to 10
	localparam int bank_w      = key_len * no_rounds;
	localparam int hold_cycles = 20;
	localparam int wdog_cycles = n_vec * 40 + 100;

	logic                 clk;
	logic                 rst_n;
	logic                 valid_in;
	round_key_t           cipher_key;
	slice_sel_t           slice_sel;
	logic [slice_w-1:0]   key_slice;
	logic [no_rounds-1:0] valid_out;

	logic [key_len-1:0]   pat_mem [0:n_vec*vec_words-1];  // one 128-bit word per line

	aes_key_wrapper #(
		.key_len   (key_len),
		.no_rounds (no_rounds)
	) dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.valid_in   (valid_in),
		.cipher_key (cipher_key),
		.slice_sel  (slice_sel),
		.key_slice  (key_slice),
		.valid_out  (valid_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;                          // 10 ns period
	end

	// prints the reason, then the fail message, and stops
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_value(input string test_name, input logic [key_len-1:0] expected,
			input logic [key_len-1:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("[ERROR] %s: expected %h, actual %h",
				test_name, expected, actual));
		end
	endtask

	// inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic apply_key(input int vec);
		cipher_key = pat_mem[vec*vec_words];
		valid_in   = 1'b1;
	endtask

	// expected bank of one vector with round r at bits 128(r-1) up
	function automatic logic [bank_w-1:0] schedule_bank(input int vec);
		logic [bank_w-1:0] bank;
		bank = '0;
		for (int r = 1; r <= no_rounds; r++) begin
			bank[key_len*(r-1) +: key_len] = pat_mem[vec*vec_words + r];
		end
		return bank;
	endfunction

	// expected valid_out in cycle n after the sampling edge
	function automatic logic [no_rounds-1:0] stage_onehot(input int cycle_no);
		logic [no_rounds-1:0] v;
		for (int i = 0; i < no_rounds; i++) begin
			v[i] = (cycle_no == i + 1);
		end
		return v;
	endfunction

	task automatic read_all_windows(input string test_name, input logic [bank_w-1:0] bank);
		logic [slice_w-1:0] expected;
		for (int k = 0; k < no_slices; k++) begin
			slice_sel = slice_sel_t'(k);
			expected  = bank[slice_w*k +: slice_w];
			@(negedge clk);                             // window settled mid cycle
			check_value($sformatf("%s window %0d", test_name, k),
				key_len'(expected), key_len'(key_slice));
			next_cycle();
		end
	endtask

	initial begin
		repeat (wdog_cycles) @(posedge clk);
		abort_run($sformatf("watchdog expired after %0d cycles, the DUT appears to hang",
			wdog_cycles));
	end

	initial begin : main_seq
		int   cycles;
		int   pulses;
		logic done;
		logic [slice_w-1:0] top_bits;

		rst_n      = 1'b0;
		valid_in   = 1'b0;
		cipher_key = '0;
		slice_sel  = '0;
		$readmemh("verif/key_patterns.hex", pat_mem);
		if ($isunknown(pat_mem[0]) || $isunknown(pat_mem[n_vec*vec_words-1])
				|| pat_mem[0] == '0) begin
			abort_run("pattern file verif/key_patterns.hex is missing or incomplete");
		end

		repeat (2) @(posedge clk);                      // reset for two edges
		#1;
		rst_n = 1'b1;

		// reset state
		@(negedge clk);
		check_value("reset valid_out", '0, key_len'(valid_out));
		next_cycle();
		read_all_windows("reset", '0);

		// single key walking one-hot down the stages
		apply_key(0);
		next_cycle();
		valid_in = 1'b0;
		cycles   = 0;
		done     = 1'b0;
		while (!done) begin
			@(negedge clk);
			cycles++;
			check_value("stage latency", key_len'(stage_onehot(cycles)), key_len'(valid_out));
			done = valid_out[no_rounds-1];
			next_cycle();
			if (!done && cycles > 2 * no_rounds) begin
				abort_run("last round valid never rose after a single key");
			end
		end
		@(negedge clk);
		check_value("stage latency", key_len'(stage_onehot(cycles + 1)), key_len'(valid_out));
		next_cycle();
		read_all_windows("single key", schedule_bank(0));

		// back to back keys read through the top window
		slice_sel = slice_sel_t'(no_slices - 1);
		for (int v = 0; v < n_vec; v++) begin
			apply_key(v);
			next_cycle();
		end
		valid_in = 1'b0;
		cycles   = 0;
		pulses   = 0;
		while (pulses < n_vec) begin
			@(negedge clk);
			cycles++;
			if (valid_out[no_rounds-1]) begin
				top_bits = pat_mem[pulses*vec_words + no_rounds][key_len-1 -: slice_w];
				check_value($sformatf("pipeline pulse %0d cycle", pulses),
					key_len'(no_rounds - n_vec + 1 + pulses), key_len'(cycles));
				check_value($sformatf("pipeline key %0d", pulses),
					key_len'(top_bits), key_len'(key_slice));
				pulses++;
			end
			next_cycle();
			if (pulses < n_vec && cycles > 3 * no_rounds) begin
				abort_run("fewer last round pulses than keys in the pipelined run");
			end
		end

		// held keys must not move while idle
		repeat (hold_cycles) next_cycle();
		@(negedge clk);
		check_value("hold valid_out", '0, key_len'(valid_out));
		next_cycle();
		read_all_windows("hold", schedule_bank(n_vec - 1));

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/key_patterns.hex */
// one 128-bit word per line, w0 in the top 32 bits
// per vector: cipher key, then round keys 1 to 10
// fips-197 appendix a.1 key
2b7e151628aed2a6abf7158809cf4f3c
a0fafe1788542cb123a339392a6c7605
f2c295f27a96b9435935807a7359f67f
3d80477d4716fe3e1e237e446d7a883b
ef44a541a8525b7fb671253bdb0bad00
d4d1c6f87c839d87caf2b8bc11f915bc
6d88a37a110b3efddbf98641ca0093fd
4e54f70e5f5fc9f384a64fb24ea6dc4f
ead27321b58dbad2312bf5607f8d292f
ac7766f319fadc2128d12941575c006e
d014f9a8c9ee2589e13f0cc8b6630ca6
// all zero key
00000000000000000000000000000000
62636363626363636263636362636363
9b9898c9f9fbfbaa9b9898c9f9fbfbaa
90973450696ccffaf2f457330b0fac99
ee06da7b876a1581759e42b27e91ee2b
7f2e2b88f8443e098dda7cbbf34b9290
ec614b851425758c99ff09376ab49ba7
217517873550620bacaf6b3cc61bf09b
0ef903333ba9613897060a04511dfa9f
b1d4d8e28a7db9da1d7bb3de4c664941
b4ef5bcb3e92e21123e951cf6f8f188e
// all ones key
ffffffffffffffffffffffffffffffff
e8e9e9e917161616e8e9e9e917161616
adaeae19bab8b80f525151e6454747f0
090e2277b3b69a78e1e7cb9ea4a08c6e
e16abd3e52dc2746b33becd8179b60b6
e5baf3ceb766d488045d385013c658e6
71d07db3c6b6a93bc2eb916bd12dc98d
e90d208d2fbb89b6ed5018dd3c7dd150
96337366b988fad054d8e20d68a5335d
8bf03f233278c5f366a027fe0e0514a3
d60a3588e472f07b82d2d7858cd7c326

/* filelist.f */
src/aes_key_pkg.sv
src/key_sbox.sv
src/round_key_gen.sv
src/key_expansion.sv
src/aes_key_wrapper.sv
verif/aes_key_wrapper_sva.sv
verif/tb_aes_key_wrapper.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the AES-128 key schedule testbench.
# Exits non-zero when the build fails or the simulation reports failure.

top=tb_aes_key_wrapper
build_dir=obj_dir
log_file=sim.log

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

rm -rf "$build_dir"

verilator --binary --timing --assert \
	--top-module "$top" \
	-Mdir "$build_dir" \
	-f filelist.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

"./$build_dir/V$top" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "TEST RESULT: FAIL" "$log_file"; then
	echo "simulation reported a failure, see $log_file"
	exit 1
fi

if [ "$run_status" -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$log_file"; then
	echo "simulation ended without a result line"
	exit 1
fi

echo "simulation passed"
exit 0
